// File: logic/fwd_defs.svh
// --------------------------------------------------
// Sizing macros for the forwarding stage
// Include wherever a width, a queue depth or the
// lane count is needed
// --------------------------------------------------

`ifndef FWD_DEFS_SVH
`define FWD_DEFS_SVH

// Packet field widths
`define FWD_DATA_W      32
`define FWD_HOPS_W      4
`define FWD_SEQ_W       8

// Destination lanes, one full flag each
`define FWD_NUM_LANES   4
`define FWD_LANE_W      2

// Queue sizing
`define FWD_FIFO_DEPTH  16
// Fill level where prog_full rises,
// leaves headroom for packets in flight
`define FWD_PROG_THRESH 8

`endif

// File: logic/route_pkg.sv
// --------------------------------------------------
// Routing metadata carried with every packet
// Referenced by scope from the stages and testbench
// --------------------------------------------------

`include "fwd_defs.svh"

package route_pkg;

    // --------------------------------------------------
    // Field types
    // --------------------------------------------------

    // Destination lane index
    typedef logic [`FWD_LANE_W-1:0] lane_t;

    // Remaining hops, zero means drop
    typedef logic [`FWD_HOPS_W-1:0] hops_t;

    // Sequence id, passed through untouched
    typedef logic [`FWD_SEQ_W-1:0] seq_t;

    // --------------------------------------------------
    // Route header
    // --------------------------------------------------

    // 14 bits total, dest in the top bits
    typedef struct packed {
        lane_t dest;
        hops_t hops;
        seq_t  seq_id;
    } route_t;

endpackage : route_pkg

// File: logic/packet_pkg.sv
// --------------------------------------------------
// Data word and full packet type
// A packet is stored whole in each queue, so the
// stages pass it as a single packed value
// --------------------------------------------------

`include "fwd_defs.svh"

package packet_pkg;

    // --------------------------------------------------
    // Payload
    // --------------------------------------------------

    // Data word, opaque to the forwarding logic
    typedef logic [`FWD_DATA_W-1:0] data_t;

    // --------------------------------------------------
    // Packet
    // --------------------------------------------------

    // Route header on top, data below
    // 46 bits with the default widths
    typedef struct packed {
        route_pkg::route_t route;
        data_t             data;
    } packet_t;

endpackage : packet_pkg

// File: logic/sync_fifo.sv
// --------------------------------------------------
// Synchronous packet queue
// FWFT=0 gives a standard read with dout one cycle
// after rd_en, FWFT=1 shows the head while not empty
// prog_full rises at PROG_THRESH entries
// --------------------------------------------------

`timescale 1ns/1ps

`include "fwd_defs.svh"

module sync_fifo #(
    parameter int DEPTH       = `FWD_FIFO_DEPTH,
    parameter int PROG_THRESH = `FWD_PROG_THRESH,
    parameter bit FWFT        = 1'b0
) (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                wr_en,
    input  packet_pkg::packet_t din,
    input  logic                rd_en,
    output packet_pkg::packet_t dout,
    output logic                valid,
    output logic                empty,
    output logic                full,
    output logic                prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    packet_pkg::packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    // Flags straight from the occupancy count
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Requests past the limits are ignored
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH, power of two not required
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count holds on a push and pop in the same cycle
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    if (FWFT) begin : g_fwft
        // Head visible combinationally
        assign dout  = mem[rd_ptr];
        assign valid = ~empty;
    end else begin : g_std
        packet_pkg::packet_t dout_q;
        logic                valid_q;

        always_ff @(posedge ap_clk) begin
            if (areset_generator) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= do_rd;
            end
        end

        // Payload register, qualified by valid_q
        always_ff @(posedge ap_clk) begin
            if (do_rd) begin
                dout_q <= mem[rd_ptr];
            end
        end

        assign dout  = dout_q;
        assign valid = valid_q;
    end

    // --------------------------------------------------
    // Protocol checks on the callers
    // --------------------------------------------------
    a_no_write_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(wr_en && full)
    );

    a_no_read_empty : assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(rd_en && empty)
    );

endmodule : sync_fifo

// File: logic/ingress_stage.sv
// --------------------------------------------------
// Ingress side of the forwarding stage
// Registers upstream inputs, queues each packet and
// pops only while egress has room
// --------------------------------------------------

`timescale 1ns/1ps

`include "fwd_defs.svh"

module ingress_stage (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                in_valid,
    input  route_pkg::lane_t    in_dest,
    input  route_pkg::hops_t    in_hops,
    input  route_pkg::seq_t     in_seq_id,
    input  packet_pkg::data_t   in_data,
    input  logic                in_pop_en,
    input  logic                egress_prog_full,
    output packet_pkg::packet_t pkt,
    output logic                pkt_valid,
    output logic                in_prog_full,
    output logic                empty
);

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    logic                in_valid_q;
    logic                pop_en_q;
    packet_pkg::packet_t in_pkt_q;

    logic fifo_rd_en;
    logic fifo_empty;
    logic fifo_prog_full;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_valid_q   <= 1'b0;
            pop_en_q     <= 1'b0;
            in_prog_full <= 1'b0;
        end else begin
            in_valid_q   <= in_valid;
            pop_en_q     <= in_pop_en;
            // Flag to upstream, one cycle late
            in_prog_full <= fifo_prog_full;
        end
    end

    // Packet assembled from the loose ports
    always_ff @(posedge ap_clk) begin
        in_pkt_q.route.dest   <= in_dest;
        in_pkt_q.route.hops   <= in_hops;
        in_pkt_q.route.seq_id <= in_seq_id;
        in_pkt_q.data         <= in_data;
    end

    // --------------------------------------------------
    // Ingress queue, standard read
    // --------------------------------------------------
    // Pop needs data, pop enable and egress below threshold
    assign fifo_rd_en = ~fifo_empty & pop_en_q & ~egress_prog_full;

    sync_fifo #(
        .DEPTH      (`FWD_FIFO_DEPTH ),
        .PROG_THRESH(`FWD_PROG_THRESH),
        .FWFT       (1'b0            )
    ) u_fifo (
        .ap_clk          (ap_clk          ),
        .areset_generator(areset_generator),
        .wr_en           (in_valid_q      ),
        .din             (in_pkt_q        ),
        .rd_en           (fifo_rd_en      ),
        .dout            (pkt             ),
        .valid           (pkt_valid       ),
        .empty           (fifo_empty      ),
        .full            (                ),
        .prog_full       (fifo_prog_full  )
    );

    assign empty = fifo_empty;

endmodule : ingress_stage

// File: logic/hop_stage.sv
// --------------------------------------------------
// Hop update between the two queues
// Drops zero-hop packets and decrements the rest
// One cycle from input valid to output valid
// --------------------------------------------------

`timescale 1ns/1ps

module hop_stage (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  packet_pkg::packet_t in_pkt,
    input  logic                in_pkt_valid,
    output packet_pkg::packet_t out_pkt,
    output logic                out_pkt_valid
);

    logic hops_left;

    // Any hop left means forward
    assign hops_left = |in_pkt.route.hops;

    // --------------------------------------------------
    // Valid dropped when no hops remain
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_pkt_valid <= 1'b0;
        end else begin
            out_pkt_valid <= in_pkt_valid & hops_left;
        end
    end

    // --------------------------------------------------
    // Payload with every field but hops copied
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        out_pkt.route.dest   <= in_pkt.route.dest;
        out_pkt.route.seq_id <= in_pkt.route.seq_id;
        out_pkt.data         <= in_pkt.data;
        // One hop used up on this stage
        out_pkt.route.hops   <= in_pkt.route.hops - 1'b1;
    end

endmodule : hop_stage

// File: logic/egress_stage.sv
// --------------------------------------------------
// Egress queue with destination-lane gating
// Head leaves only when downstream pops and its lane
// is not full; strict FIFO, a blocked head holds all
// --------------------------------------------------

`timescale 1ns/1ps

`include "fwd_defs.svh"

module egress_stage (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  packet_pkg::packet_t      pkt,
    input  logic                     pkt_valid,
    input  logic                     out_rd_en,
    input  logic [`FWD_NUM_LANES-1:0] lane_full,
    output route_pkg::lane_t         out_dest,
    output route_pkg::hops_t         out_hops,
    output route_pkg::seq_t          out_seq_id,
    output packet_pkg::data_t        out_data,
    output logic                     out_valid,
    output logic                     egress_prog_full,
    output logic                     empty
);

    packet_pkg::packet_t head;
    logic                head_valid;
    logic                head_lane_full;
    logic                release_head;

    // --------------------------------------------------
    // Egress queue, first word fall through
    // --------------------------------------------------
    sync_fifo #(
        .DEPTH      (`FWD_FIFO_DEPTH ),
        .PROG_THRESH(`FWD_PROG_THRESH),
        .FWFT       (1'b1            )
    ) u_fifo (
        .ap_clk          (ap_clk          ),
        .areset_generator(areset_generator),
        .wr_en           (pkt_valid       ),
        .din             (pkt             ),
        .rd_en           (release_head    ),
        .dout            (head            ),
        .valid           (head_valid      ),
        .empty           (empty           ),
        .full            (                ),
        .prog_full       (egress_prog_full)
    );

    // --------------------------------------------------
    // Lane gating
    // --------------------------------------------------
    // Full flag of the head's destination
    assign head_lane_full = lane_full[head.route.dest];

    assign release_head = head_valid & out_rd_en & ~head_lane_full;

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= release_head;
        end
    end

    // Fields split back onto loose ports
    always_ff @(posedge ap_clk) begin
        if (release_head) begin
            out_dest   <= head.route.dest;
            out_hops   <= head.route.hops;
            out_seq_id <= head.route.seq_id;
            out_data   <= head.data;
        end
    end

    // Delivered packet's lane was open on the cycle it left
    a_lane_open : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        out_valid |-> (($past(lane_full) & (`FWD_NUM_LANES'(1) << out_dest)) == '0)
    );

endmodule : egress_stage

// File: logic/forward_generator.sv
// --------------------------------------------------
// Forwarding stage top level
// Chains ingress queue, hop update and egress queue
// Upstream watches in_prog_full, downstream drives
// out_rd_en and one full flag per lane
// --------------------------------------------------

`timescale 1ns/1ps

`include "fwd_defs.svh"

module forward_generator (
    input  logic                      ap_clk,
    input  logic                      areset,
    // Upstream side
    input  logic                      in_valid,
    input  route_pkg::lane_t          in_dest,
    input  route_pkg::hops_t          in_hops,
    input  route_pkg::seq_t           in_seq_id,
    input  packet_pkg::data_t         in_data,
    input  logic                      in_pop_en,
    output logic                      in_prog_full,
    // Downstream side
    input  logic                      out_rd_en,
    input  logic [`FWD_NUM_LANES-1:0] lane_full,
    output logic                      out_valid,
    output route_pkg::lane_t          out_dest,
    output route_pkg::hops_t          out_hops,
    output route_pkg::seq_t           out_seq_id,
    output packet_pkg::data_t         out_data,
    output logic                      out_prog_full,
    output logic                      idle
);

    // --------------------------------------------------
    // Reset and status
    // --------------------------------------------------
    logic areset_generator;

    packet_pkg::packet_t ing_pkt;
    logic                ing_pkt_valid;
    packet_pkg::packet_t hop_pkt;
    logic                hop_pkt_valid;
    logic                egress_prog_full;
    logic                ingress_empty;
    logic                egress_empty;

    // One register stage on reset for fan-out
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_prog_full <= 1'b0;
            idle          <= 1'b1;
        end else begin
            out_prog_full <= egress_prog_full;
            // Idle only when both queues are drained
            idle          <= ingress_empty & egress_empty;
        end
    end

    // --------------------------------------------------
    // Pipeline
    // --------------------------------------------------
    ingress_stage u_ingress (
        .ap_clk          (ap_clk          ),
        .areset_generator(areset_generator),
        .in_valid        (in_valid        ),
        .in_dest         (in_dest         ),
        .in_hops         (in_hops         ),
        .in_seq_id       (in_seq_id       ),
        .in_data         (in_data         ),
        .in_pop_en       (in_pop_en       ),
        .egress_prog_full(egress_prog_full),
        .pkt             (ing_pkt         ),
        .pkt_valid       (ing_pkt_valid   ),
        .in_prog_full    (in_prog_full    ),
        .empty           (ingress_empty   )
    );

    hop_stage u_hop (
        .ap_clk          (ap_clk          ),
        .areset_generator(areset_generator),
        .in_pkt          (ing_pkt         ),
        .in_pkt_valid    (ing_pkt_valid   ),
        .out_pkt         (hop_pkt         ),
        .out_pkt_valid   (hop_pkt_valid   )
    );

    egress_stage u_egress (
        .ap_clk          (ap_clk          ),
        .areset_generator(areset_generator),
        .pkt             (hop_pkt         ),
        .pkt_valid       (hop_pkt_valid   ),
        .out_rd_en       (out_rd_en       ),
        .lane_full       (lane_full       ),
        .out_dest        (out_dest        ),
        .out_hops        (out_hops        ),
        .out_seq_id      (out_seq_id      ),
        .out_data        (out_data        ),
        .out_valid       (out_valid       ),
        .egress_prog_full(egress_prog_full),
        .empty           (egress_empty    )
    );

endmodule : forward_generator

// File: test/tb_forward_table.svh
// --------------------------------------------------
// Packet table for the forwarding testbench
// Included inside the testbench module, one row per
// packet, plus the LFSR that fills the data words
// --------------------------------------------------

`ifndef TB_FORWARD_TABLE_SVH
`define TB_FORWARD_TABLE_SVH

// Phase tags
localparam logic [1:0] PH_NORMAL = 2'd0;
localparam logic [1:0] PH_BLOCK  = 2'd1;
localparam logic [1:0] PH_BURST  = 2'd2;

// Row layout, expected hops only meaningful when fwd is set
typedef struct packed {
    route_pkg::lane_t dest;
    route_pkg::hops_t hops;
    route_pkg::seq_t  seq_id;
    logic [1:0]       phase;
    logic             fwd;
    route_pkg::hops_t exp_hops;
} row_t;

localparam int NUM_ROWS = 38;

// dest, hops, seq_id, phase, forward flag, expected hops
localparam row_t [0:NUM_ROWS-1] ROWS = {
    // Normal traffic, zero-hop packets in the middle
    {2'd0, 4'd3,  8'h00, PH_NORMAL, 1'b1, 4'd2},
    {2'd1, 4'd1,  8'h01, PH_NORMAL, 1'b1, 4'd0},
    {2'd2, 4'd0,  8'h02, PH_NORMAL, 1'b0, 4'd0},
    {2'd3, 4'd15, 8'h03, PH_NORMAL, 1'b1, 4'd14},
    {2'd0, 4'd2,  8'h04, PH_NORMAL, 1'b1, 4'd1},
    {2'd1, 4'd0,  8'h05, PH_NORMAL, 1'b0, 4'd0},
    {2'd2, 4'd7,  8'h06, PH_NORMAL, 1'b1, 4'd6},
    {2'd3, 4'd4,  8'h07, PH_NORMAL, 1'b1, 4'd3},
    // Lane 2 held full for this group
    {2'd1, 4'd2,  8'h10, PH_BLOCK,  1'b1, 4'd1},
    {2'd2, 4'd3,  8'h11, PH_BLOCK,  1'b1, 4'd2},
    {2'd3, 4'd1,  8'h12, PH_BLOCK,  1'b1, 4'd0},
    {2'd2, 4'd5,  8'h13, PH_BLOCK,  1'b1, 4'd4},
    {2'd0, 4'd0,  8'h14, PH_BLOCK,  1'b0, 4'd0},
    {2'd2, 4'd6,  8'h15, PH_BLOCK,  1'b1, 4'd5},
    // Burst with downstream stalled, longer than both thresholds
    {2'd0, 4'd1,  8'h20, PH_BURST,  1'b1, 4'd0},
    {2'd1, 4'd2,  8'h21, PH_BURST,  1'b1, 4'd1},
    {2'd2, 4'd3,  8'h22, PH_BURST,  1'b1, 4'd2},
    {2'd3, 4'd4,  8'h23, PH_BURST,  1'b1, 4'd3},
    {2'd0, 4'd5,  8'h24, PH_BURST,  1'b1, 4'd4},
    {2'd1, 4'd1,  8'h25, PH_BURST,  1'b1, 4'd0},
    {2'd2, 4'd2,  8'h26, PH_BURST,  1'b1, 4'd1},
    {2'd3, 4'd3,  8'h27, PH_BURST,  1'b1, 4'd2},
    {2'd0, 4'd4,  8'h28, PH_BURST,  1'b1, 4'd3},
    {2'd1, 4'd5,  8'h29, PH_BURST,  1'b1, 4'd4},
    {2'd2, 4'd1,  8'h2a, PH_BURST,  1'b1, 4'd0},
    {2'd3, 4'd2,  8'h2b, PH_BURST,  1'b1, 4'd1},
    {2'd0, 4'd3,  8'h2c, PH_BURST,  1'b1, 4'd2},
    {2'd1, 4'd4,  8'h2d, PH_BURST,  1'b1, 4'd3},
    {2'd2, 4'd5,  8'h2e, PH_BURST,  1'b1, 4'd4},
    {2'd3, 4'd1,  8'h2f, PH_BURST,  1'b1, 4'd0},
    {2'd0, 4'd2,  8'h30, PH_BURST,  1'b1, 4'd1},
    {2'd1, 4'd3,  8'h31, PH_BURST,  1'b1, 4'd2},
    {2'd2, 4'd4,  8'h32, PH_BURST,  1'b1, 4'd3},
    {2'd3, 4'd5,  8'h33, PH_BURST,  1'b1, 4'd4},
    {2'd0, 4'd1,  8'h34, PH_BURST,  1'b1, 4'd0},
    {2'd1, 4'd2,  8'h35, PH_BURST,  1'b1, 4'd1},
    {2'd2, 4'd3,  8'h36, PH_BURST,  1'b1, 4'd2},
    {2'd3, 4'd4,  8'h37, PH_BURST,  1'b1, 4'd3}
};

// --------------------------------------------------
// Fibonacci LFSR, taps 32 22 2 1
// --------------------------------------------------
localparam logic [31:0] LFSR_SEED = 32'hc8d5_a915;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

`endif

// File: test/tb_forward_generator.sv
// --------------------------------------------------
// Testbench for the forwarding stage
// Applies the packet table phase by phase, checks
// every delivered packet against an expected queue
// and reports one line per test
// --------------------------------------------------

`timescale 1ns/1ps

`include "fwd_defs.svh"

module tb_forward_generator;

    logic                      ap_clk;
    logic                      areset;
    logic                      in_valid;
    route_pkg::lane_t          in_dest;
    route_pkg::hops_t          in_hops;
    route_pkg::seq_t           in_seq_id;
    packet_pkg::data_t         in_data;
    logic                      in_pop_en;
    logic                      in_prog_full;
    logic                      out_rd_en;
    logic [`FWD_NUM_LANES-1:0] lane_full;
    logic                      out_valid;
    route_pkg::lane_t          out_dest;
    route_pkg::hops_t          out_hops;
    route_pkg::seq_t           out_seq_id;
    packet_pkg::data_t         out_data;
    logic                      out_prog_full;
    logic                      idle;

    `include "tb_forward_table.svh"

    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 200;

    // Scoreboard and bookkeeping
    packet_pkg::packet_t       exp_q [$];
    logic [31:0]               lfsr_state = LFSR_SEED;
    logic [`FWD_NUM_LANES-1:0] lane_prev  = '0;
    string                     test_name  = "none";
    int                        test_errs  = 0;
    int                        pass_cnt   = 0;
    int                        fail_cnt   = 0;
    int                        cycles     = 0;
    int                        out_pf_cycle = -1;
    int                        in_pf_cycle  = -1;
    bit                        watch_flags  = 1'b0;
    bit                        saw_stall    = 1'b0;

    forward_generator UUT (
        .ap_clk       (ap_clk       ),
        .areset       (areset       ),
        .in_valid     (in_valid     ),
        .in_dest      (in_dest      ),
        .in_hops      (in_hops      ),
        .in_seq_id    (in_seq_id    ),
        .in_data      (in_data      ),
        .in_pop_en    (in_pop_en    ),
        .in_prog_full (in_prog_full ),
        .out_rd_en    (out_rd_en    ),
        .lane_full    (lane_full    ),
        .out_valid    (out_valid    ),
        .out_dest     (out_dest     ),
        .out_hops     (out_hops     ),
        .out_seq_id   (out_seq_id   ),
        .out_data     (out_data     ),
        .out_prog_full(out_prog_full),
        .idle         (idle         )
    );

    // 100 ns clock
    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Reporting helpers
    // --------------------------------------------------
    task automatic value_error(input string what, input logic [63:0] expv,
                               input logic [63:0] actv);
        test_errs++;
        $display("** Error %s: %s expected %h actual %h", test_name, what, expv, actv);
    endtask

    task automatic plain_error(input string msg);
        test_errs++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test;
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS %s", test_name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", test_name, test_errs);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // One table row onto the upstream ports
    // Held off while in_prog_full is high
    task automatic push_row(input int idx);
        row_t                r;
        packet_pkg::packet_t p;
        packet_pkg::data_t   word;
        r    = ROWS[idx];
        word = '0;
        // One LFSR step per data bit
        for (int b = 0; b < `FWD_DATA_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word       = {word[`FWD_DATA_W-2:0], lfsr_state[0]};
        end
        p = {r.dest, r.exp_hops, r.seq_id, word};
        if (r.fwd) begin
            exp_q.push_back(p);
        end
        @(negedge ap_clk);
        while (in_prog_full) begin
            saw_stall = 1'b1;
            @(posedge ap_clk);
            in_valid <= 1'b0;
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        in_valid  <= 1'b1;
        in_dest   <= r.dest;
        in_hops   <= r.hops;
        in_seq_id <= r.seq_id;
        in_data   <= word;
    endtask

    // All rows of one phase back to back
    task automatic run_rows(input logic [1:0] ph);
        row_t r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = ROWS[i];
            if (r.phase == ph) begin
                push_row(i);
            end
        end
        @(posedge ap_clk);
        in_valid <= 1'b0;
    endtask

    // Until every expected packet is out and both queues are empty
    task automatic wait_drain;
        repeat (4) @(negedge ap_clk);
        while (exp_q.size() != 0 || !idle) begin
            @(negedge ap_clk);
        end
    endtask

    // --------------------------------------------------
    // Output monitor sampled mid-cycle
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        packet_pkg::packet_t got;
        packet_pkg::packet_t want;
        if (out_valid) begin
            got = {out_dest, out_hops, out_seq_id, out_data};
            // lane_prev is the flag the release was decided on
            if (lane_prev[out_dest]) begin
                plain_error($sformatf("packet for full lane %0d was delivered", out_dest));
            end
            if (exp_q.size() == 0) begin
                plain_error("a packet was delivered with none expected");
            end else begin
                want = exp_q.pop_front();
                if (got !== want) begin
                    value_error("packet", 64'(want), 64'(got));
                end
            end
        end
        lane_prev = lane_full;
        // First rise of each fill flag during the burst
        if (watch_flags && out_prog_full && out_pf_cycle < 0) begin
            out_pf_cycle = cycles;
        end
        if (watch_flags && in_prog_full && in_pf_cycle < 0) begin
            in_pf_cycle = cycles;
        end
    end

    // Run limit from the table length
    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles, %0d packets never arrived",
                     cycles, exp_q.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        areset    = 1'b1;
        in_valid  = 1'b0;
        in_dest   = '0;
        in_hops   = '0;
        in_seq_id = '0;
        in_data   = '0;
        in_pop_en = 1'b1;
        out_rd_en = 1'b1;
        lane_full = '0;
        repeat (2) @(posedge ap_clk);
        areset <= 1'b0;
        repeat (3) @(negedge ap_clk);

        begin_test("reset");
        if (out_valid !== 1'b0) begin
            value_error("out_valid", 64'd0, 64'(out_valid));
        end
        if (in_prog_full !== 1'b0) begin
            value_error("in_prog_full", 64'd0, 64'(in_prog_full));
        end
        if (out_prog_full !== 1'b0) begin
            value_error("out_prog_full", 64'd0, 64'(out_prog_full));
        end
        if (idle !== 1'b1) begin
            value_error("idle", 64'd1, 64'(idle));
        end
        end_test();

        // Forwarding and drops
        begin_test("normal");
        run_rows(PH_NORMAL);
        wait_drain();
        end_test();

        // Lane 2 held full
        // Its head blocks the queue behind it
        begin_test("lane_blocked");
        @(posedge ap_clk);
        lane_full <= 4'b0100;
        run_rows(PH_BLOCK);
        repeat (20) @(posedge ap_clk);
        lane_full <= '0;
        wait_drain();
        end_test();

        // Downstream stalled until the ingress queue pushes back
        begin_test("burst");
        @(posedge ap_clk);
        out_rd_en   <= 1'b0;
        watch_flags = 1'b1;
        fork
            run_rows(PH_BURST);
            begin
                @(negedge ap_clk);
                while (!in_prog_full) begin
                    @(negedge ap_clk);
                end
                // Both queues hold packets here
                if (idle !== 1'b0) begin
                    value_error("idle", 64'd0, 64'(idle));
                end
                repeat (10) @(posedge ap_clk);
                out_rd_en <= 1'b1;
            end
        join
        wait_drain();
        watch_flags = 1'b0;
        if (out_pf_cycle < 0) begin
            plain_error("out_prog_full never rose during the burst");
        end
        if (in_pf_cycle < 0) begin
            plain_error("in_prog_full never rose during the burst");
        end else if (in_pf_cycle < out_pf_cycle) begin
            plain_error("in_prog_full rose before out_prog_full");
        end
        if (!saw_stall) begin
            plain_error("upstream pushes never stalled on in_prog_full");
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_forward_generator

// File: forward_generator.f
+incdir+logic
+incdir+test
logic/route_pkg.sv
logic/packet_pkg.sv
logic/sync_fifo.sv
logic/ingress_stage.sv
logic/hop_stage.sv
logic/egress_stage.sv
logic/forward_generator.sv
test/tb_forward_generator.sv
